// ==== hdl/core_pkg.sv ====
// core types and constants
`default_nettype none

package core_pkg;

	typedef logic [63:0] xlen_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [7:0]  byte_en_t;
	typedef logic [1:0]  op2_src_t;

	localparam op2_src_t OP2_REG = 2'b00;
	localparam op2_src_t OP2_IMM = 2'b01;
	localparam op2_src_t OP2_4   = 2'b10; // link value pc+4

	localparam logic [6:0] OP_IMM   = 7'b0010011;
	localparam logic [6:0] OP_IMM32 = 7'b0011011;
	localparam logic [6:0] OP       = 7'b0110011;
	localparam logic [6:0] OP32     = 7'b0111011;
	localparam logic [6:0] LUI      = 7'b0110111;
	localparam logic [6:0] AUIPC    = 7'b0010111;
	localparam logic [6:0] JAL      = 7'b1101111;
	localparam logic [6:0] JALR     = 7'b1100111;
	localparam logic [6:0] BRANCH   = 7'b1100011;
	localparam logic [6:0] LOAD     = 7'b0000011;
	localparam logic [6:0] STORE    = 7'b0100011;

	localparam logic [6:0] FUN7_ALT = 7'b0100000; // sub / sra

	// branch, load/store and alu funct3
	localparam logic [2:0] FUN3_BEQ  = 3'b000, FUN3_BNE  = 3'b001;
	localparam logic [2:0] FUN3_BLT  = 3'b100, FUN3_BGE  = 3'b101;
	localparam logic [2:0] FUN3_BLTU = 3'b110, FUN3_BGEU = 3'b111;
	localparam logic [2:0] FUN3_B    = 3'b000, FUN3_H    = 3'b001;
	localparam logic [2:0] FUN3_W    = 3'b010, FUN3_D    = 3'b011;
	localparam logic [2:0] FUN3_BU   = 3'b100, FUN3_HU   = 3'b101;
	localparam logic [2:0] FUN3_WU   = 3'b110;
	localparam logic [2:0] FUN3_ADD  = 3'b000, FUN3_SL   = 3'b001;
	localparam logic [2:0] FUN3_SLT  = 3'b010, FUN3_SLTU = 3'b011;
	localparam logic [2:0] FUN3_XOR  = 3'b100, FUN3_SR   = 3'b101;
	localparam logic [2:0] FUN3_OR   = 3'b110, FUN3_AND  = 3'b111;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
		ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW
	} alu_op_t;

	typedef struct packed {
		logic      rs1_r_ena;
		reg_addr_t rs1_r_addr;
		logic      rs2_r_ena;
		reg_addr_t rs2_r_addr;
		logic      rd_w_ena;
		reg_addr_t rd_w_addr;
		alu_op_t   alu_op;
		logic      alu_op1_src; // 1 pc, 0 rs1
		op2_src_t  alu_op2_src;
		logic      branch;
		logic      jump;
		logic      pc_src;      // jalr target from rs1
		logic      mem_r_ena;
		logic      mem_w_ena;
		byte_en_t  byte_enable;
		logic      mem_ext_un;
		logic      illegal;
		xlen_t     imm;
	} id_ctrl_t;

	typedef struct packed {
		inst_t inst;
		xlen_t pc;
	} queue_entry_t;

	typedef struct packed {
		logic     we;
		xlen_t    addr;
		xlen_t    wdata;
		byte_en_t be;
		logic     ext_un;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== hdl/inst_queue.sv ====
// instruction queue
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire rst_n,
	input wire wr_en,
	input wire core_pkg::queue_entry_t wr_entry,
	output logic full,
	input wire rd_en,
	output core_pkg::queue_entry_t head,
	output logic head_valid
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	core_pkg::queue_entry_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;

	wire do_wr = wr_en & ~full; // strobe while full is lost
	wire do_rd = rd_en & head_valid;

	assign full = (count == (PTR_W+1)'(QUEUE_DEPTH));
	assign head_valid = (count != '0);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_entry;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // power of two depth wraps
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// upstream must watch in_full
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !full)
		else $error("instruction strobe dropped, queue full");

	a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> head_valid)
		else $error("pop from empty queue");

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
// rv64i instruction decoder
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input wire core_pkg::inst_t inst,
	output core_pkg::id_ctrl_t ctrl
);

	wire [6:0] opcode = inst[6:0];
	wire [4:0] rd     = inst[11:7];
	wire [2:0] func3  = inst[14:12];
	wire [4:0] rs1    = inst[19:15];
	wire [4:0] rs2    = inst[24:20];
	wire [6:0] func7  = inst[31:25];

	wire f7_zero = (func7 == 7'b0);
	wire f7_alt  = (func7 == core_pkg::FUN7_ALT);
	wire f6_zero = (inst[31:26] == 6'b0); // rv64 shamt uses bit 25
	wire f6_alt  = (inst[31:26] == core_pkg::FUN7_ALT[6:1]);

	// immediates
	wire core_pkg::xlen_t imm_i = {{52{inst[31]}}, inst[31:20]};
	wire core_pkg::xlen_t imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	wire core_pkg::xlen_t imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	wire core_pkg::xlen_t imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	wire core_pkg::xlen_t imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	wire opc_imm    = (opcode == core_pkg::OP_IMM);
	wire opc_imm32  = (opcode == core_pkg::OP_IMM32);
	wire opc_op     = (opcode == core_pkg::OP);
	wire opc_op32   = (opcode == core_pkg::OP32);
	wire opc_lui    = (opcode == core_pkg::LUI);
	wire opc_auipc  = (opcode == core_pkg::AUIPC);
	wire opc_jal    = (opcode == core_pkg::JAL);
	wire opc_jalr   = (opcode == core_pkg::JALR) & (func3 == 3'b000);
	wire opc_branch = (opcode == core_pkg::BRANCH);
	wire opc_load   = (opcode == core_pkg::LOAD);
	wire opc_store  = (opcode == core_pkg::STORE);

	wire inst_beq  = opc_branch & (func3 == core_pkg::FUN3_BEQ);
	wire inst_bne  = opc_branch & (func3 == core_pkg::FUN3_BNE);
	wire inst_blt  = opc_branch & (func3 == core_pkg::FUN3_BLT);
	wire inst_bge  = opc_branch & (func3 == core_pkg::FUN3_BGE);
	wire inst_bltu = opc_branch & (func3 == core_pkg::FUN3_BLTU);
	wire inst_bgeu = opc_branch & (func3 == core_pkg::FUN3_BGEU);

	wire ld_b  = opc_load & (func3 == core_pkg::FUN3_B);
	wire ld_h  = opc_load & (func3 == core_pkg::FUN3_H);
	wire ld_w  = opc_load & (func3 == core_pkg::FUN3_W);
	wire ld_d  = opc_load & (func3 == core_pkg::FUN3_D);
	wire ld_bu = opc_load & (func3 == core_pkg::FUN3_BU);
	wire ld_hu = opc_load & (func3 == core_pkg::FUN3_HU);
	wire ld_wu = opc_load & (func3 == core_pkg::FUN3_WU);
	wire st_b  = opc_store & (func3 == core_pkg::FUN3_B);
	wire st_h  = opc_store & (func3 == core_pkg::FUN3_H);
	wire st_w  = opc_store & (func3 == core_pkg::FUN3_W);
	wire st_d  = opc_store & (func3 == core_pkg::FUN3_D);

	wire inst_addi  = opc_imm & (func3 == core_pkg::FUN3_ADD);
	wire inst_slti  = opc_imm & (func3 == core_pkg::FUN3_SLT);
	wire inst_sltiu = opc_imm & (func3 == core_pkg::FUN3_SLTU);
	wire inst_xori  = opc_imm & (func3 == core_pkg::FUN3_XOR);
	wire inst_ori   = opc_imm & (func3 == core_pkg::FUN3_OR);
	wire inst_andi  = opc_imm & (func3 == core_pkg::FUN3_AND);
	wire inst_slli  = opc_imm & (func3 == core_pkg::FUN3_SL) & f6_zero;
	wire inst_srli  = opc_imm & (func3 == core_pkg::FUN3_SR) & f6_zero;
	wire inst_srai  = opc_imm & (func3 == core_pkg::FUN3_SR) & f6_alt;

	// mul/div share these opcodes with func7 01, so f7 checks keep them out
	wire inst_add  = opc_op & (func3 == core_pkg::FUN3_ADD) & f7_zero;
	wire inst_sub  = opc_op & (func3 == core_pkg::FUN3_ADD) & f7_alt;
	wire inst_sll  = opc_op & (func3 == core_pkg::FUN3_SL) & f7_zero;
	wire inst_slt  = opc_op & (func3 == core_pkg::FUN3_SLT) & f7_zero;
	wire inst_sltu = opc_op & (func3 == core_pkg::FUN3_SLTU) & f7_zero;
	wire inst_xor  = opc_op & (func3 == core_pkg::FUN3_XOR) & f7_zero;
	wire inst_srl  = opc_op & (func3 == core_pkg::FUN3_SR) & f7_zero;
	wire inst_sra  = opc_op & (func3 == core_pkg::FUN3_SR) & f7_alt;
	wire inst_or   = opc_op & (func3 == core_pkg::FUN3_OR) & f7_zero;
	wire inst_and  = opc_op & (func3 == core_pkg::FUN3_AND) & f7_zero;

	wire inst_addiw = opc_imm32 & (func3 == core_pkg::FUN3_ADD);
	wire inst_slliw = opc_imm32 & (func3 == core_pkg::FUN3_SL) & f7_zero;
	wire inst_srliw = opc_imm32 & (func3 == core_pkg::FUN3_SR) & f7_zero;
	wire inst_sraiw = opc_imm32 & (func3 == core_pkg::FUN3_SR) & f7_alt;
	wire inst_addw  = opc_op32 & (func3 == core_pkg::FUN3_ADD) & f7_zero;
	wire inst_subw  = opc_op32 & (func3 == core_pkg::FUN3_ADD) & f7_alt;
	wire inst_sllw  = opc_op32 & (func3 == core_pkg::FUN3_SL) & f7_zero;
	wire inst_srlw  = opc_op32 & (func3 == core_pkg::FUN3_SR) & f7_zero;
	wire inst_sraw  = opc_op32 & (func3 == core_pkg::FUN3_SR) & f7_alt;

	wire is_br   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
	wire is_ld   = ld_b | ld_h | ld_w | ld_d | ld_bu | ld_hu | ld_wu;
	wire is_st   = st_b | st_h | st_w | st_d;
	wire is_imm  = inst_addi | inst_slti | inst_sltiu | inst_xori | inst_ori | inst_andi
		| inst_slli | inst_srli | inst_srai;
	wire is_op   = inst_add | inst_sub | inst_sll | inst_slt | inst_sltu | inst_xor
		| inst_srl | inst_sra | inst_or | inst_and;
	wire is_word = inst_addiw | inst_slliw | inst_srliw | inst_sraiw | inst_addw
		| inst_subw | inst_sllw | inst_srlw | inst_sraw;
	wire legal = is_br | is_ld | is_st | is_imm | is_op | is_word
		| opc_lui | opc_auipc | opc_jal | opc_jalr;

	always_comb begin
		ctrl = '0;
		ctrl.illegal = ~legal;
		ctrl.rs1_r_addr = rs1;
		ctrl.rs2_r_addr = rs2;
		ctrl.rd_w_addr = rd;
		ctrl.rs1_r_ena = opc_jalr | is_br | is_ld | is_st | is_imm | is_op | is_word;
		ctrl.rs2_r_ena = is_br | is_st | is_op | inst_addw | inst_subw
			| inst_sllw | inst_srlw | inst_sraw;
		ctrl.rd_w_ena = legal & ~is_br & ~is_st;
		ctrl.alu_op1_src = opc_auipc | opc_jal | opc_jalr;
		if (opc_jal | opc_jalr)
			ctrl.alu_op2_src = core_pkg::OP2_4;
		else if (ctrl.rs2_r_ena & ~is_st)
			ctrl.alu_op2_src = core_pkg::OP2_REG;
		else
			ctrl.alu_op2_src = core_pkg::OP2_IMM;
		ctrl.branch = is_br;
		ctrl.jump = opc_jal | opc_jalr;
		ctrl.pc_src = opc_jalr;
		ctrl.mem_r_ena = is_ld;
		ctrl.mem_w_ena = is_st;
		ctrl.mem_ext_un = ld_bu | ld_hu | ld_wu;
		ctrl.byte_enable = ({8{ld_b | ld_bu | st_b}} & 8'h01)
			| ({8{ld_h | ld_hu | st_h}} & 8'h03)
			| ({8{ld_w | ld_wu | st_w}} & 8'h0f)
			| ({8{ld_d | st_d}} & 8'hff);
		ctrl.imm = ({64{opc_lui | opc_auipc}} & imm_u)
			| ({64{opc_jal}} & imm_j)
			| ({64{opc_branch}} & imm_b)
			| ({64{opc_jalr | opc_load | opc_imm | opc_imm32}} & imm_i)
			| ({64{opc_store}} & imm_s);

		if (inst_sub)                      ctrl.alu_op = core_pkg::ALU_SUB;
		else if (inst_slt | inst_slti)     ctrl.alu_op = core_pkg::ALU_SLT;
		else if (inst_sltu | inst_sltiu)   ctrl.alu_op = core_pkg::ALU_SLTU;
		else if (inst_xor | inst_xori)     ctrl.alu_op = core_pkg::ALU_XOR;
		else if (inst_or | inst_ori)       ctrl.alu_op = core_pkg::ALU_OR;
		else if (inst_and | inst_andi)     ctrl.alu_op = core_pkg::ALU_AND;
		else if (inst_sll | inst_slli)     ctrl.alu_op = core_pkg::ALU_SLL;
		else if (inst_srl | inst_srli)     ctrl.alu_op = core_pkg::ALU_SRL;
		else if (inst_sra | inst_srai)     ctrl.alu_op = core_pkg::ALU_SRA;
		else if (opc_lui)                  ctrl.alu_op = core_pkg::ALU_LUI;
		else if (inst_beq)                 ctrl.alu_op = core_pkg::ALU_BEQ;
		else if (inst_bne)                 ctrl.alu_op = core_pkg::ALU_BNE;
		else if (inst_blt)                 ctrl.alu_op = core_pkg::ALU_BLT;
		else if (inst_bge)                 ctrl.alu_op = core_pkg::ALU_BGE;
		else if (inst_bltu)                ctrl.alu_op = core_pkg::ALU_BLTU;
		else if (inst_bgeu)                ctrl.alu_op = core_pkg::ALU_BGEU;
		else if (inst_addw | inst_addiw)   ctrl.alu_op = core_pkg::ALU_ADDW;
		else if (inst_subw)                ctrl.alu_op = core_pkg::ALU_SUBW;
		else if (inst_sllw | inst_slliw)   ctrl.alu_op = core_pkg::ALU_SLLW;
		else if (inst_srlw | inst_srliw)   ctrl.alu_op = core_pkg::ALU_SRLW;
		else if (inst_sraw | inst_sraiw)   ctrl.alu_op = core_pkg::ALU_SRAW;
		else                               ctrl.alu_op = core_pkg::ALU_ADD; // addr, auipc, link
	end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
// integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input wire clk,
	input wire rst_n,
	input wire core_pkg::reg_addr_t raddr1,
	input wire core_pkg::reg_addr_t raddr2,
	output core_pkg::xlen_t rdata1,
	output core_pkg::xlen_t rdata2,
	input wire we,
	input wire core_pkg::reg_addr_t waddr,
	input wire core_pkg::xlen_t wdata
);

	core_pkg::xlen_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 hardwired
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hdl/exe_stage.sv ====
// single cycle execute stage
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
	input wire clk,
	input wire rst_n,
	input wire retire,
	input wire core_pkg::xlen_t pc,
	input wire core_pkg::id_ctrl_t ctrl,
	input wire core_pkg::xlen_t rs1_data,
	input wire core_pkg::xlen_t rs2_data,
	output logic wb_we,
	output core_pkg::reg_addr_t wb_addr,
	output core_pkg::xlen_t wb_data,
	output logic res_valid,
	output core_pkg::xlen_t res_pc,
	output core_pkg::reg_addr_t res_rd,
	output core_pkg::xlen_t res_value,
	output logic res_wen,
	output logic br_taken,
	output core_pkg::xlen_t br_target,
	output logic mem_req,
	output core_pkg::mem_req_t mem,
	output logic illegal
);

	core_pkg::xlen_t src1, src2, op1, op2, alu_res, target;
	logic [31:0] word_res;
	logic cond;
	logic word_op;

	assign src1 = ctrl.rs1_r_ena ? rs1_data : '0; // unread operands stay zero
	assign src2 = ctrl.rs2_r_ena ? rs2_data : '0;
	assign op1 = ctrl.alu_op1_src ? pc : src1;

	always_comb begin
		case (ctrl.alu_op2_src)
			core_pkg::OP2_IMM: op2 = ctrl.imm;
			core_pkg::OP2_4:   op2 = 64'd4;
			default:           op2 = src2;
		endcase
	end

	always_comb begin
		alu_res = '0;
		word_res = '0;
		cond = 1'b0;
		word_op = 1'b0;
		case (ctrl.alu_op)
			core_pkg::ALU_ADD:  alu_res = op1 + op2;
			core_pkg::ALU_SUB:  alu_res = op1 - op2;
			core_pkg::ALU_SLT:  alu_res = {63'd0, $signed(op1) < $signed(op2)};
			core_pkg::ALU_SLTU: alu_res = {63'd0, op1 < op2};
			core_pkg::ALU_XOR:  alu_res = op1 ^ op2;
			core_pkg::ALU_OR:   alu_res = op1 | op2;
			core_pkg::ALU_AND:  alu_res = op1 & op2;
			core_pkg::ALU_SLL:  alu_res = op1 << op2[5:0];
			core_pkg::ALU_SRL:  alu_res = op1 >> op2[5:0];
			core_pkg::ALU_SRA:  alu_res = $signed(op1) >>> op2[5:0];
			core_pkg::ALU_LUI:  alu_res = op2;
			core_pkg::ALU_BEQ:  cond = (op1 == op2);
			core_pkg::ALU_BNE:  cond = (op1 != op2);
			core_pkg::ALU_BLT:  cond = ($signed(op1) < $signed(op2));
			core_pkg::ALU_BGE:  cond = ($signed(op1) >= $signed(op2));
			core_pkg::ALU_BLTU: cond = (op1 < op2);
			core_pkg::ALU_BGEU: cond = (op1 >= op2);
			core_pkg::ALU_ADDW: word_res = op1[31:0] + op2[31:0];
			core_pkg::ALU_SUBW: word_res = op1[31:0] - op2[31:0];
			core_pkg::ALU_SLLW: word_res = op1[31:0] << op2[4:0];
			core_pkg::ALU_SRLW: word_res = op1[31:0] >> op2[4:0];
			core_pkg::ALU_SRAW: word_res = $signed(op1[31:0]) >>> op2[4:0];
			default: ;
		endcase
		word_op = ctrl.alu_op inside {core_pkg::ALU_ADDW, core_pkg::ALU_SUBW,
			core_pkg::ALU_SLLW, core_pkg::ALU_SRLW, core_pkg::ALU_SRAW};
		if (word_op)
			alu_res = {{32{word_res[31]}}, word_res};
		else if (ctrl.branch)
			alu_res = {63'd0, cond};
	end

	// jalr drops bit 0 of rs1+imm
	assign target = ctrl.pc_src ? ((src1 + ctrl.imm) & ~64'd1) : (pc + ctrl.imm);

	assign wb_we = retire & ctrl.rd_w_ena & ~ctrl.mem_r_ena; // no load data back
	assign wb_addr = ctrl.rd_w_addr;
	assign wb_data = alu_res;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			mem_req <= 1'b0;
			illegal <= 1'b0;
		end else begin
			res_valid <= retire;
			mem_req <= retire & (ctrl.mem_r_ena | ctrl.mem_w_ena);
			illegal <= retire & ctrl.illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (retire) begin
			res_pc <= pc;
			res_rd <= ctrl.rd_w_addr;
			res_value <= alu_res;
			res_wen <= wb_we;
			br_taken <= ctrl.jump | (ctrl.branch & cond);
			br_target <= target;
			mem.we <= ctrl.mem_w_ena;
			mem.addr <= alu_res;
			mem.wdata <= src2; // store data
			mem.be <= ctrl.byte_enable;
			mem.ext_un <= ctrl.mem_ext_un;
		end
	end

	// decoder clears mem enables on illegal words
	a_mem_not_illegal: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_req && illegal))
		else $error("memory request from an illegal instruction");

endmodule

`default_nettype wire

// ==== hdl/decode_top.sv ====
// in-order decode front end
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	input wire core_pkg::inst_t in_inst,
	input wire core_pkg::xlen_t in_pc,
	output logic in_full,
	input wire hold,
	output logic res_valid,
	output core_pkg::xlen_t res_pc,
	output core_pkg::reg_addr_t res_rd,
	output core_pkg::xlen_t res_value,
	output logic res_wen,
	output logic br_taken,
	output core_pkg::xlen_t br_target,
	output logic mem_req,
	output core_pkg::mem_req_t mem,
	output logic illegal
);

	core_pkg::queue_entry_t head;
	core_pkg::id_ctrl_t ctrl;
	core_pkg::xlen_t rs1_data, rs2_data, wb_data;
	core_pkg::reg_addr_t wb_addr;
	logic head_valid;
	logic wb_we;

	wire retire = head_valid & ~hold; // pop and retire together

	inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clk(clk), .rst_n(rst_n),
		.wr_en(in_valid), .wr_entry({in_inst, in_pc}), .full(in_full),
		.rd_en(retire), .head(head), .head_valid(head_valid)
	);

	id_stage u_id (.inst(head.inst), .ctrl(ctrl));

	regfile u_regs (
		.clk(clk), .rst_n(rst_n),
		.raddr1(ctrl.rs1_r_addr), .raddr2(ctrl.rs2_r_addr),
		.rdata1(rs1_data), .rdata2(rs2_data),
		.we(wb_we), .waddr(wb_addr), .wdata(wb_data)
	);

	exe_stage u_exe (
		.clk(clk), .rst_n(rst_n), .retire(retire), .pc(head.pc), .ctrl(ctrl),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
		.res_valid(res_valid), .res_pc(res_pc), .res_rd(res_rd),
		.res_value(res_value), .res_wen(res_wen),
		.br_taken(br_taken), .br_target(br_target),
		.mem_req(mem_req), .mem(mem), .illegal(illegal)
	);

endmodule

`default_nettype wire

// ==== test/tb_vectors.svh ====
// decode front end program table
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam logic [6:0] OPC_IMM    = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP32   = 7'b0111011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

localparam int N_FIXED = 28;

// pc of row n is 0x1000 + 4n
task automatic fill_table;
	// immediate and upper immediate ops
	alu_row("addi x1,x0,5", i_form(OPC_IMM, 0, 1, 0, 5), 1, 64'd5);
	alu_row("addi x2,x0,-3", i_form(OPC_IMM, 0, 2, 0, -3), 2, 64'hffff_ffff_ffff_fffd);
	alu_row("xori x3,x1,0xf0", i_form(OPC_IMM, 4, 3, 1, 'hf0), 3, 64'hf5);
	alu_row("slti x4,x2,-2", i_form(OPC_IMM, 2, 4, 2, -2), 4, 64'd1);
	alu_row("slli x5,x1,40", i_form(OPC_IMM, 1, 5, 1, 40), 5, 64'h0000_0500_0000_0000);
	alu_row("srai x6,x2,1", i_form(OPC_IMM, 5, 6, 2, 'h401), 6, 64'hffff_ffff_ffff_fffe);
	alu_row("lui x7,0x80000", u_form(OPC_LUI, 7, 'h80000), 7, 64'hffff_ffff_8000_0000);
	alu_row("auipc x8,0x1", u_form(OPC_AUIPC, 8, 1), 8, 64'h201c);
	// register and word ops
	alu_row("add x9,x1,x2", r_form(OPC_OP, 0, 0, 9, 1, 2), 9, 64'd2);
	alu_row("sub x10,x1,x2", r_form(OPC_OP, 0, 'h20, 10, 1, 2), 10, 64'd8);
	alu_row("sltu x11,x1,x2", r_form(OPC_OP, 3, 0, 11, 1, 2), 11, 64'd1);
	alu_row("addw x12,x1,x7", r_form(OPC_OP32, 0, 0, 12, 1, 7), 12, 64'hffff_ffff_8000_0005);
	alu_row("sraw x13,x7,x1", r_form(OPC_OP32, 5, 'h20, 13, 7, 1), 13, 64'hffff_ffff_fc00_0000);
	// jumps and branches
	jump_row("jal x14,+16", j_form(14, 16), 14, 1'b1, 64'h1038, 1'b1, 64'h1044);
	jump_row("jalr x15,3(x10)", i_form(OPC_JALR, 0, 15, 10, 3), 15, 1'b1, 64'h103c, 1'b1, 64'ha);
	jump_row("beq x1,x9,+8", b_form(0, 1, 9, 8), 0, 1'b0, 64'd0, 1'b0, 64'h1044);
	jump_row("blt x2,x1,-16", b_form(4, 2, 1, -16), 0, 1'b0, 64'd0, 1'b1, 64'h1030);
	jump_row("beq x4,x11,+12", b_form(0, 4, 11, 12), 0, 1'b0, 64'd0, 1'b1, 64'h1050);
	// loads and stores
	mem_row("lb x16,1(x3)", i_form(OPC_LOAD, 0, 16, 3, 1), 1'b0, 64'hf6, 8'h01,
		64'd0, 1'b0);
	mem_row("lbu x25,-1(x10)", i_form(OPC_LOAD, 4, 25, 10, -1), 1'b0, 64'h7, 8'h01,
		64'd0, 1'b1);
	mem_row("lw x17,-4(x10)", i_form(OPC_LOAD, 2, 17, 10, -4), 1'b0, 64'h4, 8'h0f,
		64'd0, 1'b0);
	mem_row("sd x7,16(x3)", s_form(3, 3, 7, 16), 1'b1, 64'h105, 8'hff,
		64'hffff_ffff_8000_0000, 1'b0);
	alu_row("addi x0,x1,7", i_form(OPC_IMM, 0, 0, 1, 7), 0, 64'd12);
	alu_row("add x18,x0,x1", r_form(OPC_OP, 0, 0, 18, 0, 1), 18, 64'd5);
	alu_row("addi x19,x16,1", i_form(OPC_IMM, 0, 19, 16, 1), 19, 64'd1); // load left x16 alone
	// illegal words
	bad_row("mul x20,x1,x2", r_form(OPC_OP, 0, 1, 20, 1, 2));
	bad_row("csrrw x21,mstatus,x1", i_form(OPC_SYSTEM, 1, 21, 1, 'h300));
	alu_row("addi x22,x20,9", i_form(OPC_IMM, 0, 22, 20, 9), 22, 64'd9);
endtask

`endif

// ==== test/tb_decode_top.sv ====
// decode front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

	localparam int QUEUE_DEPTH = 4;
	localparam logic [63:0] PC_BASE = 64'h1000;

	typedef struct packed {
		core_pkg::inst_t     inst;
		core_pkg::xlen_t     pc;
		logic                wen;
		core_pkg::reg_addr_t rd;
		core_pkg::xlen_t     value;
		logic                cf;     // target is checked
		logic                taken;
		core_pkg::xlen_t     target;
		logic                mreq;
		logic                mwe;
		core_pkg::xlen_t     addr;
		logic [7:0]          be;
		core_pkg::xlen_t     wdata;
		logic                ext_un;
		logic                ill;
	} vec_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	core_pkg::inst_t in_inst;
	core_pkg::xlen_t in_pc;
	logic in_full;
	logic hold;
	logic res_valid;
	core_pkg::xlen_t res_pc;
	core_pkg::reg_addr_t res_rd;
	core_pkg::xlen_t res_value;
	logic res_wen;
	logic br_taken;
	core_pkg::xlen_t br_target;
	logic mem_req;
	core_pkg::mem_req_t mem;
	logic illegal;

	vec_t rows[$];
	string row_name[$];
	int got;
	int errors;
	int tests_run;
	int tests_failed;
	int cycles;
	integer seed;
	logic hold_seen;

	decode_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) uut (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_inst(in_inst), .in_pc(in_pc), .in_full(in_full),
		.hold(hold),
		.res_valid(res_valid), .res_pc(res_pc), .res_rd(res_rd),
		.res_value(res_value), .res_wen(res_wen),
		.br_taken(br_taken), .br_target(br_target),
		.mem_req(mem_req), .mem(mem), .illegal(illegal)
	);

	// instruction encoders
	function automatic core_pkg::inst_t i_form(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic core_pkg::inst_t r_form(logic [6:0] opc, logic [2:0] f3, logic [6:0] f7,
			logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic core_pkg::inst_t s_form(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
			logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic core_pkg::inst_t b_form(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
			logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic core_pkg::inst_t u_form(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic core_pkg::inst_t j_form(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic vec_t blank_row(input core_pkg::inst_t inst);
		vec_t v;
		v = '0;
		v.inst = inst;
		v.pc = PC_BASE + 64'(4 * rows.size());
		return v;
	endfunction

	task automatic push_row(input string name, input vec_t v);
		rows.push_back(v);
		row_name.push_back(name);
	endtask

	task automatic alu_row(input string name, input core_pkg::inst_t inst, input logic [4:0] rd,
			input core_pkg::xlen_t value);
		vec_t v;
		v = blank_row(inst);
		v.wen = 1'b1;
		v.rd = rd;
		v.value = value;
		push_row(name, v);
	endtask

	task automatic jump_row(input string name, input core_pkg::inst_t inst, input logic [4:0] rd,
			input logic wen, input core_pkg::xlen_t value, input logic taken,
			input core_pkg::xlen_t target);
		vec_t v;
		v = blank_row(inst);
		v.wen = wen;
		v.rd = rd;
		v.value = value;
		v.cf = 1'b1;
		v.taken = taken;
		v.target = target;
		push_row(name, v);
	endtask

	task automatic mem_row(input string name, input core_pkg::inst_t inst, input logic we,
			input core_pkg::xlen_t addr, input logic [7:0] be, input core_pkg::xlen_t wdata,
			input logic ext_un);
		vec_t v;
		v = blank_row(inst);
		v.mreq = 1'b1;
		v.mwe = we;
		v.addr = addr;
		v.be = be;
		v.wdata = wdata;
		v.ext_un = ext_un;
		push_row(name, v);
	endtask

	task automatic bad_row(input string name, input core_pkg::inst_t inst);
		vec_t v;
		v = blank_row(inst);
		v.ill = 1'b1;
		push_row(name, v);
	endtask

	`include "tb_vectors.svh"

	localparam int N_ROWS = N_FIXED + QUEUE_DEPTH;
	localparam int TIMEOUT = N_ROWS * 4 + 100;

	task automatic check(input string name, input string field, input logic [63:0] exp,
			input logic [63:0] act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %h, actual %h", name, field, exp, act);
			errors++;
		end
	endtask

	task automatic record_test(input string name, input int e0);
		tests_run++;
		if (errors != e0) begin
			tests_failed++;
			$display("bad  %s", name);
		end else begin
			$display("ok   %s", name);
		end
	endtask

	task automatic compare_row(input int idx);
		vec_t v;
		string n;
		int e0;
		v = rows[idx];
		n = row_name[idx];
		e0 = errors;
		check(n, "res_pc", v.pc, res_pc);
		check(n, "res_wen", 64'(v.wen), 64'(res_wen));
		check(n, "illegal", 64'(v.ill), 64'(illegal));
		check(n, "mem_req", 64'(v.mreq), 64'(mem_req));
		check(n, "br_taken", 64'(v.taken), 64'(br_taken));
		if (v.wen) begin
			check(n, "res_rd", 64'(v.rd), 64'(res_rd));
			check(n, "res_value", v.value, res_value);
		end
		if (v.cf)
			check(n, "br_target", v.target, br_target);
		if (v.mreq) begin
			check(n, "mem.we", 64'(v.mwe), 64'(mem.we));
			check(n, "mem.addr", v.addr, mem.addr);
			check(n, "mem.be", 64'(v.be), 64'(mem.be));
			check(n, "mem.ext_un", 64'(v.ext_un), 64'(mem.ext_un));
			if (v.mwe)
				check(n, "mem.wdata", v.wdata, mem.wdata);
		end
		record_test(n, e0);
	endtask

	task automatic put_row(input int idx);
		in_valid = 1'b1;
		in_inst = rows[idx].inst;
		in_pc = rows[idx].pc;
	endtask

	always #5 clk = ~clk;

	always @(posedge clk) hold_seen <= hold; // hold as seen by the edge

	// match each result to the next row at the falling edge
	always @(negedge clk) begin
		if (res_valid === 1'b1) begin
			if (hold_seen === 1'b1) begin
				$display("res_valid rose after an edge where hold was high");
				errors++;
			end
			if (got < rows.size()) begin
				compare_row(got);
				got++;
			end else begin
				$display("res_valid pulse with no table row left, pc %h", res_pc);
				errors++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("timeout after %0d cycles, %0d of %0d results seen", cycles, got, N_ROWS);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		int i;
		int e0;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_inst = '0;
		in_pc = '0;
		hold = 1'b0;
		seed = 32'ha6c3;
		got = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;

		fill_table();
		for (int k = 1; k <= QUEUE_DEPTH; k++)
			alu_row($sformatf("addi x24,x24,1 burst %0d", k), i_form(OPC_IMM, 0, 24, 24, 1),
				24, 64'(k));
		if (rows.size() != N_ROWS) begin
			$display("table holds %0d rows instead of %0d", rows.size(), N_ROWS);
			errors++;
		end

		repeat (8) @(posedge clk);
		@(negedge clk);
		e0 = errors;
		check("reset", "in_full", 64'd0, 64'(in_full));
		check("reset", "res_valid", 64'd0, 64'(res_valid));
		check("reset", "mem_req", 64'd0, 64'(mem_req));
		check("reset", "illegal", 64'd0, 64'(illegal));
		record_test("reset", e0);
		rst_n = 1'b1;

		// program rows with random back-pressure
		i = 0;
		while (i < N_FIXED) begin
			@(negedge clk);
			hold = ($random(seed) & 3) == 0;
			if (in_full) begin
				in_valid = 1'b0;
			end else begin
				put_row(i);
				i++;
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
		hold = 1'b0;
		wait (got == N_FIXED);

		// fill the queue while held
		@(negedge clk);
		e0 = errors;
		hold = 1'b1;
		for (i = N_FIXED; i < N_ROWS; i++) begin
			check("queue full", "in_full before push", 64'd0, 64'(in_full));
			put_row(i);
			@(negedge clk);
		end
		in_valid = 1'b0;
		check("queue full", "in_full after pushes", 64'd1, 64'(in_full));
		repeat (3) @(negedge clk);
		check("queue full", "in_full while held", 64'd1, 64'(in_full));
		record_test("queue full under hold", e0);
		hold = 1'b0;
		wait (got == N_ROWS);
		repeat (3) @(negedge clk);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
hdl/core_pkg.sv
hdl/inst_queue.sv
hdl/id_stage.sv
hdl/regfile.sv
hdl/exe_stage.sv
hdl/decode_top.sv
test/tb_decode_top.sv

// ==== Makefile ====
# Verilator build and run for the decode front end

VERILATOR ?= verilator
TOP       ?= tb_decode_top
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
